//--- alu_unit.sv
`timescale 1ns/1ps
`include "rv_exec_defs.svh"
`default_nettype none

module alu_unit import rv_exec_pkg::*; (
	dec_if.dst dec,
	res_if.src res
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7;
	src_sel_e   src_sel;
	lsu_op_e    lsu_opt;
	alu_op_e    alu_opt;
	instr_t     ins;
	word_t      imm;
	word_t      op_a;
	word_t      op_b;
	word_t      alu_out;
	word_t      addr;
	logic       taken;

	assign ins    = dec.instr;
	assign opcode = ins[6:0];
	assign funct3 = ins[14:12];
	assign funct7 = ins[30];

	id_opt id_opt_inst (
		.opcode  (opcode),
		.funct3  (funct3),
		.funct7  (funct7),
		.src_sel (src_sel),
		.lsu_opt (lsu_opt),
		.alu_opt (alu_opt)
	);

	always_comb begin
		case (opcode)
			`OPC_LOAD, `OPC_OP_IMM, `OPC_JALR, `OPC_FENCE, `OPC_SYS:
				imm = {{20{ins[31]}}, ins[31:20]};
			`OPC_STORE:
				imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			`OPC_BRANCH:
				imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			`OPC_LUI, `OPC_AUIPC:
				imm = {ins[31:12], 12'b0};
			`OPC_JAL:
				imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

	always_comb begin
		case (src_sel)
			SRC_PC_IMM  : begin op_a = dec.pc;       op_b = imm;              end
			SRC_PC_4    : begin op_a = dec.pc;       op_b = word_t'(4);       end
			SRC_RS1_RS2 : begin op_a = dec.rs1_data; op_b = dec.rs2_data;     end
			default     : begin op_a = dec.rs1_data; op_b = imm;              end
		endcase
	end

	always_comb begin
		case (alu_opt)
			ALU_ADD  : alu_out = op_a + op_b;
			ALU_SUB  : alu_out = op_a - op_b;
			ALU_SLT  : alu_out = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU : alu_out = word_t'(op_a < op_b);
			ALU_XOR  : alu_out = op_a ^ op_b;
			ALU_OR   : alu_out = op_a | op_b;
			ALU_AND  : alu_out = op_a & op_b;
			ALU_SLL  : alu_out = op_a << op_b[4:0];
			ALU_SRL  : alu_out = op_a >> op_b[4:0];
			ALU_SRA  : alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
			default  : alu_out = '0;
		endcase
	end

	assign addr = dec.rs1_data + imm;   // effective address for ld/st

	always_comb begin
		taken = 1'b0;
		if (opcode == `OPC_BRANCH) begin
			case (funct3)
				`F3_BEQ  : taken = (alu_out == '0);
				`F3_BNE  : taken = (alu_out != '0);
				`F3_BLT  : taken = alu_out[0];
				`F3_BLTU : taken = alu_out[0];
				`F3_BGE  : taken = ~alu_out[0];
				`F3_BGEU : taken = ~alu_out[0];
				default  : taken = 1'b0;
			endcase
		end
	end

	assign res.valid        = dec.valid;
	assign dec.ready        = res.ready;
	assign res.lsu_op       = lsu_opt;
	assign res.branch_taken = taken;
	assign res.result       = (lsu_opt == LSU_LOAD || lsu_opt == LSU_STORE) ? addr : alu_out;

endmodule

`default_nettype wire

//--- exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_if import rv_exec_pkg::*; ();
	logic   valid;
	logic   ready;
	instr_t instr;
	word_t  pc;
	word_t  rs1_data;
	word_t  rs2_data;

	modport src (output valid, instr, pc, rs1_data, rs2_data, input ready);
	modport dst (input valid, instr, pc, rs1_data, rs2_data, output ready);
endinterface

interface res_if import rv_exec_pkg::*; ();
	logic    valid;
	logic    ready;
	word_t   result;
	lsu_op_e lsu_op;
	logic    branch_taken;

	modport src (output valid, result, lsu_op, branch_taken, input ready);
	modport dst (input valid, result, lsu_op, branch_taken, output ready);
endinterface

`default_nettype wire

//--- id_opt.sv
`timescale 1ns/1ps
`include "rv_exec_defs.svh"
`default_nettype none

module id_opt import rv_exec_pkg::*; (
	input  logic [6:0] opcode,
	input  logic [2:0] funct3,
	input  logic       funct7,    // instr bit 30
	output src_sel_e   src_sel,
	output lsu_op_e    lsu_opt,
	output alu_op_e    alu_opt
);

	always_comb begin
		alu_opt = ALU_NONE;
		case (opcode)
			`OPC_LUI    : alu_opt = ALU_ADD;
			`OPC_AUIPC  : alu_opt = ALU_ADD;
			`OPC_JAL    : alu_opt = ALU_ADD;
			`OPC_JALR   : alu_opt = ALU_ADD;
			`OPC_BRANCH : begin
				case (funct3)
					`F3_BEQ  : alu_opt = ALU_SUB;
					`F3_BNE  : alu_opt = ALU_SUB;
					`F3_BLT  : alu_opt = ALU_SLT;
					`F3_BGE  : alu_opt = ALU_SLT;
					`F3_BLTU : alu_opt = ALU_SLTU;
					`F3_BGEU : alu_opt = ALU_SLTU;
					default  : alu_opt = ALU_NONE;
				endcase
			end
			`OPC_LOAD   : alu_opt = ALU_NONE;   // address adder instead
			`OPC_STORE  : alu_opt = ALU_NONE;
			`OPC_OP_IMM : begin
				case (funct3)
					`F3_ADD  : alu_opt = ALU_ADD;    // addi, no subi
					`F3_SLT  : alu_opt = ALU_SLT;    // slti signed
					`F3_SLTU : alu_opt = ALU_SLTU;
					`F3_XOR  : alu_opt = ALU_XOR;
					`F3_OR   : alu_opt = ALU_OR;
					`F3_AND  : alu_opt = ALU_AND;
					`F3_SLL  : alu_opt = ALU_SLL;
					`F3_SR   : begin
						if (funct7) begin
							alu_opt = ALU_SRA;   // srai
						end else begin
							alu_opt = ALU_SRL;   // srli
						end
					end
					default  : alu_opt = ALU_NONE;
				endcase
			end
			`OPC_OP     : begin
				case (funct3)
					`F3_ADD  : begin
						if (funct7) begin
							alu_opt = ALU_SUB;
						end else begin
							alu_opt = ALU_ADD;
						end
					end
					`F3_SLL  : alu_opt = ALU_SLL;
					`F3_SLT  : alu_opt = ALU_SLT;
					`F3_SLTU : alu_opt = ALU_SLTU;
					`F3_XOR  : alu_opt = ALU_XOR;
					`F3_SR   : begin
						if (funct7) begin
							alu_opt = ALU_SRA;
						end else begin
							alu_opt = ALU_SRL;
						end
					end
					`F3_OR   : alu_opt = ALU_OR;
					`F3_AND  : alu_opt = ALU_AND;
					default  : alu_opt = ALU_NONE;
				endcase
			end
			`OPC_FENCE  : alu_opt = ALU_AND;
			`OPC_SYS    : alu_opt = ALU_AND;
			default     : alu_opt = ALU_NONE;   // unknown opcode gives zero
		endcase
	end

	always_comb begin
		case (opcode)
			`OPC_LUI    : src_sel = SRC_RS1_IMM;   // rs1 is zero here
			`OPC_AUIPC  : src_sel = SRC_PC_IMM;
			`OPC_JAL    : src_sel = SRC_PC_4;
			`OPC_JALR   : src_sel = SRC_PC_4;
			`OPC_BRANCH : src_sel = SRC_RS1_RS2;
			`OPC_LOAD   : src_sel = SRC_RS1_IMM;
			`OPC_STORE  : src_sel = SRC_RS1_IMM;
			`OPC_OP_IMM : src_sel = SRC_RS1_IMM;
			`OPC_OP     : src_sel = SRC_RS1_RS2;
			`OPC_FENCE  : src_sel = SRC_RS1_IMM;
			`OPC_SYS    : src_sel = SRC_RS1_IMM;
			default     : src_sel = SRC_RS1_IMM;
		endcase
	end

	always_comb begin
		case (opcode)
			`OPC_LOAD  : lsu_opt = LSU_LOAD;
			`OPC_STORE : lsu_opt = LSU_STORE;
			`OPC_SYS   : lsu_opt = LSU_SYS;
			default    : lsu_opt = LSU_NONE;
		endcase
	end

endmodule

`default_nettype wire

//--- instr_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module instr_ingress import rv_exec_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   in_valid,
	output logic   in_ready,
	input  instr_t in_instr,
	input  word_t  in_pc,
	input  word_t  in_rs1_data,
	input  word_t  in_rs2_data,
	dec_if.src     dec
);

	logic   full;
	logic   leaving;
	logic   load;
	instr_t instr_q;
	word_t  pc_q;
	word_t  rs1_q;
	word_t  rs2_q;

	assign leaving  = full & dec.ready;
	assign in_ready = ~full | dec.ready;   // free now or emptied this edge
	assign load     = in_valid & in_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (leaving) begin
			full <= 1'b0;
		end
	end

	// payload only
	always_ff @(posedge clk) begin
		if (load) begin
			instr_q <= in_instr;
			pc_q    <= in_pc;
			rs1_q   <= in_rs1_data;
			rs2_q   <= in_rs2_data;
		end
	end

	assign dec.valid    = full;
	assign dec.instr    = instr_q;
	assign dec.pc       = pc_q;
	assign dec.rs1_data = rs1_q;
	assign dec.rs2_data = rs2_q;

endmodule

`default_nettype wire

//--- list.f
+incdir+.
rv_exec_pkg.sv
exec_if.sv
instr_ingress.sv
id_opt.sv
alu_unit.sv
result_egress.sv
rv_exec_top.sv
tb_rv_exec.sv

//--- result_egress.sv
`timescale 1ns/1ps
`include "rv_exec_defs.svh"
`default_nettype none

module result_egress import rv_exec_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	res_if.dst      res,
	output logic    out_valid,
	input  logic    out_ready,
	output word_t   out_result,
	output lsu_op_e out_lsu_op,
	output logic    out_branch_taken
);

	localparam int DEPTH = `RES_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	word_t            mem_result [DEPTH];
	lsu_op_e          mem_lsu    [DEPTH];
	logic [DEPTH-1:0] mem_taken;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign res.ready = (count != CNT_W'(DEPTH));   // not full
	assign out_valid = (count != '0);
	assign push      = res.valid & res.ready;
	assign pop       = out_valid & out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10   : count <= count + 1'b1;
				2'b01   : count <= count - 1'b1;
				default : count <= count;   // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_result[wr_ptr] <= res.result;
			mem_lsu[wr_ptr]    <= res.lsu_op;
			mem_taken[wr_ptr]  <= res.branch_taken;
		end
	end

	assign out_result       = mem_result[rd_ptr];
	assign out_lsu_op       = mem_lsu[rd_ptr];
	assign out_branch_taken = mem_taken[rd_ptr];

endmodule

`default_nettype wire

//--- rv_exec_defs.svh
`default_nettype none

`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

`define XLEN            32
`define RES_FIFO_DEPTH  2

`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_FENCE   7'b0001111
`define OPC_SYS     7'b1110011

// funct3 for OP and OP_IMM
`define F3_ADD   3'b000
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SR    3'b101
`define F3_OR    3'b110
`define F3_AND   3'b111

// funct3 for BRANCH
`define F3_BEQ   3'b000
`define F3_BNE   3'b001
`define F3_BLT   3'b100
`define F3_BGE   3'b101
`define F3_BLTU  3'b110
`define F3_BGEU  3'b111

`endif

`default_nettype wire

//--- rv_exec_pkg.sv
`include "rv_exec_defs.svh"
`default_nettype none

package rv_exec_pkg;

	typedef logic [`XLEN-1:0] word_t;   // operands, pc, result
	typedef logic [31:0] instr_t;

	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	// operand pair fed to the alu
	typedef enum logic [1:0] {
		SRC_RS1_IMM,
		SRC_PC_IMM,
		SRC_PC_4,
		SRC_RS1_RS2
	} src_sel_e;

	typedef enum logic [1:0] {
		LSU_NONE,
		LSU_LOAD,
		LSU_STORE,
		LSU_SYS
	} lsu_op_e;

endpackage

`default_nettype wire

//--- rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    in_valid,
	output logic    in_ready,
	input  instr_t  in_instr,
	input  word_t   in_pc,
	input  word_t   in_rs1_data,
	input  word_t   in_rs2_data,
	output logic    out_valid,
	input  logic    out_ready,
	output word_t   out_result,
	output lsu_op_e out_lsu_op,
	output logic    out_branch_taken
);

	dec_if dec_bus ();
	res_if res_bus ();

	instr_ingress instr_ingress_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_instr    (in_instr),
		.in_pc       (in_pc),
		.in_rs1_data (in_rs1_data),
		.in_rs2_data (in_rs2_data),
		.dec         (dec_bus.src)
	);

	// decode and execute, same cycle
	alu_unit alu_unit_inst (
		.dec (dec_bus.dst),
		.res (res_bus.src)
	);

	result_egress result_egress_inst (
		.clk              (clk),
		.arst_n           (arst_n),
		.res              (res_bus.dst),
		.out_valid        (out_valid),
		.out_ready        (out_ready),
		.out_result       (out_result),
		.out_lsu_op       (out_lsu_op),
		.out_branch_taken (out_branch_taken)
	);

endmodule

`default_nettype wire

//--- tb_rv_exec.sv
`timescale 1ns/1ps
`include "rv_exec_defs.svh"
`default_nettype none

module tb_rv_exec import rv_exec_pkg::*; ();

	localparam int TOTAL_INSTR = 88;                  // 1 + 39 + 18 + 10 + 20
	localparam int LIMIT       = 2 * TOTAL_INSTR + 200;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	logic        in_ready;
	instr_t      in_instr;
	word_t       in_pc;
	word_t       in_rs1_data;
	word_t       in_rs2_data;
	logic        out_valid;
	logic        out_ready;
	word_t       out_result;
	lsu_op_e     out_lsu_op;
	logic        out_branch_taken;
	logic [34:0] exp_q [$];                            // {result, lsu_op, taken}
	logic [34:0] exp_beat;
	logic [34:0] got_beat;
	logic [31:0] lfsr;
	string       cur_test;
	int          errs;
	int          n_pass;
	int          n_fail;
	int          beats;
	int          cyc;
	logic        saw_backpressure;

	rv_exec_top rv_exec_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("timeout after %0d cycles in test %s", cyc, cur_test);
			$display("TB FAILED");
			$finish;
		end
	end

	// a beat seen here is popped at the next rising edge
	always @(negedge clk) begin
		if (in_valid && !in_ready) begin
			saw_backpressure = 1'b1;
		end
		if (out_valid && out_ready) begin
			beats++;
			assert (exp_q.size() > 0) else begin
				$display("unexpected output beat in test %s", cur_test);
				errs++;
			end
			if (exp_q.size() > 0) begin
				exp_beat = exp_q.pop_front();
				got_beat = {out_result, out_lsu_op, out_branch_taken};
				assert (got_beat == exp_beat) else begin
					$display("Mismatch %s: expected %h lsu %0d br %0b, actual %h lsu %0d br %0b",
						cur_test, exp_beat[34:3], exp_beat[2:1], exp_beat[0],
						got_beat[34:3], got_beat[2:1], got_beat[0]);
					errs++;
				end
			end
		end
	end

	// galois lfsr, one step per bit
	function automatic word_t rand_bits(input int n);
		word_t r;
		int    k;
		r = '0;
		for (k = 0; k < n; k++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
		end
		return r;
	endfunction

	function automatic word_t op_result(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		word_t r;
		case (f3)
			`F3_ADD  : r = alt ? a - b : a + b;
			`F3_SLL  : r = a << b[4:0];
			`F3_SLT  : r = word_t'($signed(a) < $signed(b));
			`F3_SLTU : r = word_t'(a < b);
			`F3_XOR  : r = a ^ b;
			`F3_OR   : r = a | b;
			`F3_AND  : r = a & b;
			default  : begin
				if (alt) begin
					r = $signed(a) >>> b[4:0];
				end else begin
					r = a >> b[4:0];
				end
			end
		endcase
		return r;
	endfunction

	function automatic logic [34:0] expect_beat(input instr_t i, input word_t pc,
		input word_t a, input word_t b);
		word_t   imm_i;
		word_t   imm_s;
		word_t   imm_u;
		word_t   r;
		lsu_op_e l;
		logic    t;
		logic    lt_s;
		logic    lt_u;
		imm_i = {{20{i[31]}}, i[31:20]};
		imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
		imm_u = {i[31:12], 12'b0};
		lt_s  = $signed(a) < $signed(b);
		lt_u  = a < b;
		r = '0;
		l = LSU_NONE;
		t = 1'b0;
		case (i[6:0])
			`OPC_LUI    : r = a + imm_u;               // rs1 is zero by convention
			`OPC_AUIPC  : r = pc + imm_u;
			`OPC_JAL    : r = pc + 4;
			`OPC_JALR   : r = pc + 4;
			`OPC_BRANCH : begin
				case (i[14:12])
					`F3_BEQ  : begin r = a - b; t = (a == b); end
					`F3_BNE  : begin r = a - b; t = (a != b); end
					`F3_BLT  : begin r = word_t'(lt_s); t = lt_s; end
					`F3_BGE  : begin r = word_t'(lt_s); t = !lt_s; end
					`F3_BLTU : begin r = word_t'(lt_u); t = lt_u; end
					`F3_BGEU : begin r = word_t'(lt_u); t = !lt_u; end
					default  : r = '0;
				endcase
			end
			`OPC_LOAD   : begin r = a + imm_i; l = LSU_LOAD; end
			`OPC_STORE  : begin r = a + imm_s; l = LSU_STORE; end
			`OPC_OP_IMM : r = op_result(i[14:12], i[30] && i[14:12] == `F3_SR, a, imm_i);
			`OPC_OP     : r = op_result(i[14:12], i[30], a, b);
			`OPC_FENCE  : r = a & imm_i;
			`OPC_SYS    : begin r = a & imm_i; l = LSU_SYS; end
			default     : r = '0;
		endcase
		return {r, l, t};
	endfunction

	function automatic instr_t arith_instr(input logic [6:0] opc, input logic [2:0] f3,
		input logic alt);
		logic [11:0] hi;
		hi = 12'(rand_bits(12));
		if (opc == `OPC_OP || f3 == `F3_SLL || f3 == `F3_SR) begin
			hi[11:5] = {1'b0, alt, 5'b0};           // legal funct7
		end
		return {hi, 5'(rand_bits(5)), f3, 5'd1, opc};
	endfunction

	task automatic send(input instr_t ins, input word_t pc, input word_t a, input word_t b);
		logic ok;
		exp_q.push_back(expect_beat(ins, pc, a, b));
		in_valid    = 1'b1;
		in_instr    = ins;
		in_pc       = pc;
		in_rs1_data = a;
		in_rs2_data = b;
		ok = 1'b0;
		while (!ok) begin
			@(negedge clk);
			ok = in_ready;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(negedge clk);
		assert (!out_valid) else begin
			$display("extra output beat after all results in test %s", cur_test);
			errs++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic finish_test(input int e0);
		if (errs == e0) begin
			n_pass++;
			$display("test %s passed", cur_test);
		end else begin
			n_fail++;
			$display("test %s failed with %0d errors", cur_test, errs - e0);
		end
	endtask

	task automatic latency_after_reset();
		int e0;
		e0 = errs;
		cur_test = "reset_latency";
		assert (!out_valid && in_ready) else begin
			$display("after reset out_valid is high or in_ready is low");
			errs++;
		end
		send(arith_instr(`OPC_OP_IMM, `F3_ADD, 1'b0), rand_bits(32), rand_bits(32), '0);
		@(negedge clk);
		assert (!out_valid) else begin
			$display("result appeared one cycle after acceptance");
			errs++;
		end
		@(negedge clk);
		assert (out_valid) else begin
			$display("result missing two cycles after acceptance");
			errs++;
		end
		drain();
		finish_test(e0);
	endtask

	task automatic arith_ops();
		int e0;
		int rep;
		int f;
		e0 = errs;
		cur_test = "arith";
		for (rep = 0; rep < 2; rep++) begin
			for (f = 0; f < 8; f++) begin
				send(arith_instr(`OPC_OP, 3'(f), 1'b0), '0, rand_bits(32), rand_bits(32));
				if (f == 0 || f == 5) begin
					send(arith_instr(`OPC_OP, 3'(f), 1'b1), '0, rand_bits(32), rand_bits(32));
				end
				send(arith_instr(`OPC_OP_IMM, 3'(f), 1'b0), '0, rand_bits(32), rand_bits(32));
				if (f == 5) begin
					send(arith_instr(`OPC_OP_IMM, 3'(f), 1'b1), '0, rand_bits(32), '0);
				end
			end
		end
		send({12'd3, 5'd1, `F3_SLT, 5'd6, `OPC_OP_IMM}, '0, 32'hFFFF_FFFB, '0);   // -5 < 3
		drain();
		finish_test(e0);
	endtask

	task automatic branch_conds();
		logic [2:0] conds [6];
		word_t      pa [3];
		word_t      pb [3];
		int         e0;
		int         c;
		int         p;
		e0 = errs;
		cur_test = "branches";
		conds = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
		pa[0] = rand_bits(32);
		pb[0] = pa[0];
		pa[1] = 32'hFFFF_FFFD;                     // signed less, unsigned greater
		pb[1] = 32'd5;
		pa[2] = 32'd5;
		pb[2] = 32'hFFFF_FFFD;
		for (c = 0; c < 6; c++) begin
			for (p = 0; p < 3; p++) begin
				send({7'(rand_bits(7)), 5'd2, 5'd1, conds[c], 5'(rand_bits(5)), `OPC_BRANCH},
					rand_bits(32), pa[p], pb[p]);
			end
		end
		drain();
		finish_test(e0);
	endtask

	task automatic operand_sources();
		logic [6:0] opcs [10];
		word_t      a;
		int         e0;
		int         k;
		e0 = errs;
		cur_test = "sources";
		opcs = '{`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_LOAD, `OPC_STORE,
			`OPC_FENCE, `OPC_SYS, 7'b1111111, 7'b0000000};
		for (k = 0; k < 10; k++) begin
			a = (opcs[k] == `OPC_LUI) ? '0 : rand_bits(32);
			send({25'(rand_bits(25)), opcs[k]}, rand_bits(32), a, rand_bits(32));
		end
		drain();
		finish_test(e0);
	endtask

	task automatic stalled_burst();
		instr_t ins [20];
		word_t  ra [20];
		word_t  rb [20];
		logic   issued;
		int     e0;
		int     k;
		int     n;
		e0 = errs;
		cur_test = "backpressure";
		for (k = 0; k < 20; k++) begin
			ins[k] = arith_instr(rand_bits(1) ? `OPC_OP : `OPC_OP_IMM, 3'(rand_bits(3)),
				1'(rand_bits(1)));
			ra[k] = rand_bits(32);
			rb[k] = rand_bits(32);
		end
		beats = 0;
		saw_backpressure = 1'b0;
		issued = 1'b0;
		fork
			begin
				for (k = 0; k < 20; k++) begin
					send(ins[k], '0, ra[k], rb[k]);
				end
				issued = 1'b1;
			end
			begin
				n = 0;
				while (!issued || exp_q.size() != 0) begin
					out_ready = (n >= 6) ? 1'(rand_bits(1)) : 1'b0;   // fill the fifo first
					n++;
					@(posedge clk);
					#1;
				end
				out_ready = 1'b1;
			end
		join
		drain();
		assert (beats == 20) else begin
			$display("Mismatch %s: expected %0d beats, actual %0d", cur_test, 20, beats);
			errs++;
		end
		assert (saw_backpressure) else begin
			$display("in_ready never dropped while the output was stalled");
			errs++;
		end
		finish_test(e0);
	endtask

	initial begin
		lfsr        = 32'd3307;
		errs        = 0;
		n_pass      = 0;
		n_fail      = 0;
		beats       = 0;
		cyc         = 0;
		cur_test    = "reset";
		saw_backpressure = 1'b0;
		arst_n      = 1'b0;
		in_valid    = 1'b0;
		in_instr    = '0;
		in_pc       = '0;
		in_rs1_data = '0;
		in_rs2_data = '0;
		out_ready   = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		latency_after_reset();
		arith_ops();
		branch_conds();
		operand_sources();
		stalled_burst();
		$display("tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, errs);
		if (errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
